/* verilog/axi_lite_async_pkg.sv */
package axi_lite_async_pkg;

  localparam int ADDR_WIDTH   = 32;
  localparam int DATA_WIDTH   = 32;
  localparam int STRB_WIDTH   = 4;

  localparam int BUFFER_WIDTH   = 4; // fifo depth in slots and the width of each token vector.
  localparam int SLOT_IDX_WIDTH = $clog2(BUFFER_WIDTH);

  localparam int REG_COUNT     = 16;
  localparam int REG_IDX_WIDTH = $clog2(REG_COUNT);
  localparam logic [ADDR_WIDTH-1:0] REG_BASE = 32'h0000_1000;

  localparam logic [1:0] RESP_OKAY   = 2'b00;
  localparam logic [1:0] RESP_SLVERR = 2'b10;

  typedef enum logic
  {
    OP_READ  = 1'b0,
    OP_WRITE = 1'b1
  } bridge_op_e;

  typedef enum logic [1:0]
  {
    IDLE = 2'd0,
    SEND = 2'd1,
    RESP = 2'd2
  } slave_state_e;

  // one request crossing from the cluster side to the soc side.
  typedef struct packed
  {
    bridge_op_e              op;
    logic [ADDR_WIDTH-1:0]   addr;
    logic [DATA_WIDTH-1:0]   wdata;
    logic [STRB_WIDTH-1:0]   wstrb;
  } bridge_req_t;

  // the op travels back so the slave knows which channel to answer on.
  typedef struct packed
  {
    bridge_op_e              op;
    logic [1:0]              resp;
    logic [DATA_WIDTH-1:0]   rdata;
  } bridge_resp_t;

  localparam int REQ_WIDTH  = $bits(bridge_req_t);
  localparam int RESP_WIDTH = $bits(bridge_resp_t);

endpackage

/* verilog/level_shift_sync_wrap.sv */
`timescale 1ns/1ps

module level_shift_sync_wrap import axi_lite_async_pkg::*;
#(
  parameter int DATA_WIDTH = 32
)
(
  input  logic                                    wr_clk_i,
  input  logic                                    rd_clk_i,
  input  logic                                    reset_i,

  input  logic [BUFFER_WIDTH-1:0][DATA_WIDTH-1:0] slot_data_i,
  output logic [BUFFER_WIDTH-1:0][DATA_WIDTH-1:0] slot_data_o,

  input  logic [BUFFER_WIDTH-1:0]                 writetoken_i,
  output logic [BUFFER_WIDTH-1:0]                 writetoken_sync_o,

  input  logic [BUFFER_WIDTH-1:0]                 readpointer_i,
  output logic [BUFFER_WIDTH-1:0]                 readpointer_sync_o
);

  logic [BUFFER_WIDTH-1:0] writetoken_ls;
  logic [BUFFER_WIDTH-1:0] readpointer_ls;
  logic [BUFFER_WIDTH-1:0] writetoken_meta;
  logic [BUFFER_WIDTH-1:0] readpointer_meta;

  genvar s;
  genvar b;

  generate
    for (s = 0; s < BUFFER_WIDTH; s++)
    begin : slot_ls
      for (b = 0; b < DATA_WIDTH; b++)
      begin : data_ls
        buf lev_shifter_data (slot_data_o[s][b], slot_data_i[s][b]);
      end
      buf lev_shifter_writetoken (writetoken_ls[s], writetoken_i[s]); // toward the read side.
      buf lev_shifter_readpointer (readpointer_ls[s], readpointer_i[s]); // back to the write side.
    end
  endgenerate

  always_ff @(posedge rd_clk_i)
  begin
    if (reset_i)
    begin
      writetoken_meta   <= '0;
      writetoken_sync_o <= '0;
    end
    else
    begin
      writetoken_meta   <= writetoken_ls;
      writetoken_sync_o <= writetoken_meta;
    end
  end

  always_ff @(posedge wr_clk_i)
  begin
    if (reset_i)
    begin
      readpointer_meta   <= '0;
      readpointer_sync_o <= '0;
    end
    else
    begin
      readpointer_meta   <= readpointer_ls;
      readpointer_sync_o <= readpointer_meta;
    end
  end

endmodule

/* verilog/async_token_fifo.sv */
`timescale 1ns/1ps

module async_token_fifo import axi_lite_async_pkg::*;
#(
  parameter int DATA_WIDTH = 32
)
(
  input  logic                  wr_clk_i,
  input  logic                  rd_clk_i,
  input  logic                  reset_i,

  input  logic [DATA_WIDTH-1:0] wr_data_i,
  input  logic                  wr_valid_i,
  output logic                  wr_ready_o,

  output logic [DATA_WIDTH-1:0] rd_data_o,
  output logic                  rd_valid_o,
  input  logic                  rd_ready_i
);

  logic [BUFFER_WIDTH-1:0][DATA_WIDTH-1:0] slot_q;
  logic [BUFFER_WIDTH-1:0][DATA_WIDTH-1:0] slot_rd;
  logic [SLOT_IDX_WIDTH-1:0]               wr_idx_q;
  logic [SLOT_IDX_WIDTH-1:0]               wr_idx_next;
  logic [BUFFER_WIDTH-1:0]                 writetoken_q;
  logic [BUFFER_WIDTH-1:0]                 writetoken_next;
  logic [BUFFER_WIDTH-1:0]                 writetoken_sync;
  logic [BUFFER_WIDTH-1:0]                 readpointer_q;
  logic [BUFFER_WIDTH-1:0]                 readpointer_sync;
  logic                                    wr_ready_q;
  logic                                    wr_fire;
  logic [SLOT_IDX_WIDTH-1:0]               rd_idx_q;
  logic                                    rd_valid_q;
  logic [DATA_WIDTH-1:0]                   rd_data_q;
  logic                                    slot_avail;
  logic                                    rd_load;

  assign wr_ready_o = wr_ready_q;
  assign wr_fire    = wr_valid_i && wr_ready_q;

  always_comb
  begin
    writetoken_next = writetoken_q;
    wr_idx_next     = wr_idx_q;
    if (wr_fire)
    begin
      writetoken_next[wr_idx_q] = ~writetoken_q[wr_idx_q];
      wr_idx_next               = wr_idx_q + 1'b1;
    end
  end

  always_ff @(posedge wr_clk_i)
  begin
    if (reset_i)
    begin
      wr_idx_q     <= '0;
      writetoken_q <= '0;
      wr_ready_q   <= 1'b0;
    end
    else
    begin
      wr_idx_q     <= wr_idx_next;
      writetoken_q <= writetoken_next;
      wr_ready_q   <= (writetoken_next[wr_idx_next] == readpointer_sync[wr_idx_next]);
    end
  end

  always_ff @(posedge wr_clk_i)
  begin
    if (wr_fire)
      slot_q[wr_idx_q] <= wr_data_i;
  end

  level_shift_sync_wrap #(
    .DATA_WIDTH (DATA_WIDTH)
  ) i_cross (
    .wr_clk_i           (wr_clk_i),
    .rd_clk_i           (rd_clk_i),
    .reset_i            (reset_i),
    .slot_data_i        (slot_q),
    .slot_data_o        (slot_rd),
    .writetoken_i       (writetoken_q),
    .writetoken_sync_o  (writetoken_sync),
    .readpointer_i      (readpointer_q),
    .readpointer_sync_o (readpointer_sync)
  );

  // a slot holds data while its two token bits differ.
  assign slot_avail = writetoken_sync[rd_idx_q] ^ readpointer_q[rd_idx_q];
  assign rd_load    = slot_avail && (!rd_valid_q || rd_ready_i);

  always_ff @(posedge rd_clk_i)
  begin
    if (reset_i)
    begin
      rd_idx_q      <= '0;
      readpointer_q <= '0;
      rd_valid_q    <= 1'b0;
    end
    else if (rd_load)
    begin
      readpointer_q[rd_idx_q] <= ~readpointer_q[rd_idx_q]; // hands the slot back.
      rd_idx_q                <= rd_idx_q + 1'b1;
      rd_valid_q              <= 1'b1;
    end
    else if (rd_ready_i)
      rd_valid_q <= 1'b0;
  end

  always_ff @(posedge rd_clk_i)
  begin
    if (rd_load)
      rd_data_q <= slot_rd[rd_idx_q];
  end

  assign rd_valid_o = rd_valid_q;
  assign rd_data_o  = rd_data_q;

  a_no_overwrite: assert property (@(posedge wr_clk_i) disable iff (reset_i)
    wr_valid_i && wr_ready_o |-> writetoken_q[wr_idx_q] == readpointer_sync[wr_idx_q]);

endmodule

/* verilog/axi_lite_req_slave.sv */
`timescale 1ns/1ps

module axi_lite_req_slave import axi_lite_async_pkg::*;
(
  input  logic                  clk_i,
  input  logic                  reset_i,

  input  logic [ADDR_WIDTH-1:0] awaddr_i,
  input  logic                  awvalid_i,
  output logic                  awready_o,

  input  logic [DATA_WIDTH-1:0] wdata_i,
  input  logic [STRB_WIDTH-1:0] wstrb_i,
  input  logic                  wvalid_i,
  output logic                  wready_o,

  output logic [1:0]            bresp_o,
  output logic                  bvalid_o,
  input  logic                  bready_i,

  input  logic [ADDR_WIDTH-1:0] araddr_i,
  input  logic                  arvalid_i,
  output logic                  arready_o,

  output logic [DATA_WIDTH-1:0] rdata_o,
  output logic [1:0]            rresp_o,
  output logic                  rvalid_o,
  input  logic                  rready_i,

  output bridge_req_t           req_o,
  output logic                  req_valid_o,
  input  logic                  req_ready_i,

  input  bridge_resp_t          resp_i,
  input  logic                  resp_valid_i,
  output logic                  resp_ready_o
);

  slave_state_e state_q;
  bridge_req_t  req_q;
  bridge_resp_t resp_q;
  logic         bvalid_q;
  logic         rvalid_q;
  logic         wr_accept;
  logic         rd_accept;
  logic         resp_fire;
  logic         resp_done;

  assign wr_accept = (state_q == IDLE) && awvalid_i && wvalid_i;
  assign rd_accept = (state_q == IDLE) && arvalid_i && !(awvalid_i && wvalid_i); // writes win.

  assign awready_o = wr_accept;
  assign wready_o  = wr_accept;
  assign arready_o = rd_accept;

  assign req_o        = req_q;
  assign req_valid_o  = (state_q == SEND);
  assign resp_ready_o = (state_q == RESP) && !bvalid_q && !rvalid_q;

  assign resp_fire = resp_valid_i && resp_ready_o;
  assign resp_done = (bvalid_q && bready_i) || (rvalid_q && rready_i);

  assign bvalid_o = bvalid_q;
  assign bresp_o  = resp_q.resp;
  assign rvalid_o = rvalid_q;
  assign rresp_o  = resp_q.resp;
  assign rdata_o  = resp_q.rdata;

  always_ff @(posedge clk_i)
  begin
    if (reset_i)
    begin
      state_q  <= IDLE;
      bvalid_q <= 1'b0;
      rvalid_q <= 1'b0;
    end
    else
    begin
      case (state_q)
        IDLE:
        begin
          if (wr_accept || rd_accept)
            state_q <= SEND;
        end
        SEND:
        begin
          if (req_ready_i)
            state_q <= RESP;
        end
        RESP:
        begin
          if (resp_fire)
          begin
            bvalid_q <= (resp_i.op == OP_WRITE);
            rvalid_q <= (resp_i.op == OP_READ);
          end
          else if (resp_done)
          begin
            bvalid_q <= 1'b0;
            rvalid_q <= 1'b0;
            state_q  <= IDLE;
          end
        end
        default: state_q <= IDLE;
      endcase
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (wr_accept)
      req_q <= '{op: OP_WRITE, addr: awaddr_i, wdata: wdata_i, wstrb: wstrb_i};
    else if (rd_accept)
      req_q <= '{op: OP_READ, addr: araddr_i, wdata: '0, wstrb: '0};
    if (resp_fire)
      resp_q <= resp_i;
  end

  a_bvalid_hold: assert property (@(posedge clk_i) disable iff (reset_i)
    bvalid_o && !bready_i |=> bvalid_o && $stable(bresp_o));

  a_b_r_exclusive: assert property (@(posedge clk_i) disable iff (reset_i)
    !(bvalid_o && rvalid_o));

endmodule

/* verilog/reg_bank_target.sv */
`timescale 1ns/1ps

module reg_bank_target import axi_lite_async_pkg::*;
(
  input  logic         soc_clk_i,
  input  logic         reset_i,

  input  bridge_req_t  req_i,
  input  logic         req_valid_i,
  output logic         req_ready_o,

  output bridge_resp_t resp_o,
  output logic         resp_valid_o,
  input  logic         resp_ready_i
);

  logic [DATA_WIDTH-1:0]    regs_q [REG_COUNT];
  bridge_req_t              req_q;
  logic                     pend_q;
  bridge_resp_t             resp_q;
  logic                     resp_valid_q;
  logic [ADDR_WIDTH-1:0]    offset;
  logic                     hit;
  logic [REG_IDX_WIDTH-1:0] reg_idx;
  logic                     req_fire;

  // pop only when the response slot is free, so a full response fifo stalls requests.
  assign req_ready_o = !pend_q && !resp_valid_q;
  assign req_fire    = req_valid_i && req_ready_o;

  assign offset  = req_q.addr - REG_BASE;
  assign hit     = (offset < ADDR_WIDTH'(REG_COUNT * 4)) && (offset[1:0] == 2'b00);
  assign reg_idx = offset[REG_IDX_WIDTH+1:2];

  always_ff @(posedge soc_clk_i)
  begin
    if (reset_i)
    begin
      pend_q       <= 1'b0;
      resp_valid_q <= 1'b0;
      for (int i = 0; i < REG_COUNT; i++)
        regs_q[i] <= '0;
    end
    else
    begin
      if (req_fire)
        pend_q <= 1'b1;
      if (pend_q)
      begin
        pend_q       <= 1'b0;
        resp_valid_q <= 1'b1;
        if (hit && (req_q.op == OP_WRITE))
        begin
          for (int k = 0; k < STRB_WIDTH; k++)
          begin
            if (req_q.wstrb[k])
              regs_q[reg_idx][8*k +: 8] <= req_q.wdata[8*k +: 8];
          end
        end
      end
      else if (resp_valid_q && resp_ready_i)
        resp_valid_q <= 1'b0;
    end
  end

  always_ff @(posedge soc_clk_i)
  begin
    if (req_fire)
      req_q <= req_i;
    if (pend_q)
    begin
      resp_q.op    <= req_q.op;
      resp_q.resp  <= hit ? RESP_OKAY : RESP_SLVERR;
      resp_q.rdata <= (hit && (req_q.op == OP_READ)) ? regs_q[reg_idx] : '0;
    end
  end

  assign resp_o       = resp_q;
  assign resp_valid_o = resp_valid_q;

endmodule

/* verilog/axi_lite_async_bridge_top.sv */
`timescale 1ns/1ps

module axi_lite_async_bridge_top import axi_lite_async_pkg::*;
(
  input  logic                  clk_i,
  input  logic                  soc_clk_i,
  input  logic                  reset_i,

  input  logic [ADDR_WIDTH-1:0] awaddr_i,
  input  logic                  awvalid_i,
  output logic                  awready_o,

  input  logic [DATA_WIDTH-1:0] wdata_i,
  input  logic [STRB_WIDTH-1:0] wstrb_i,
  input  logic                  wvalid_i,
  output logic                  wready_o,

  output logic [1:0]            bresp_o,
  output logic                  bvalid_o,
  input  logic                  bready_i,

  input  logic [ADDR_WIDTH-1:0] araddr_i,
  input  logic                  arvalid_i,
  output logic                  arready_o,

  output logic [DATA_WIDTH-1:0] rdata_o,
  output logic [1:0]            rresp_o,
  output logic                  rvalid_o,
  input  logic                  rready_i
);

  bridge_req_t  req_cl;
  logic         req_cl_valid;
  logic         req_cl_ready;
  bridge_req_t  req_soc;
  logic         req_soc_valid;
  logic         req_soc_ready;
  bridge_resp_t resp_soc;
  logic         resp_soc_valid;
  logic         resp_soc_ready;
  bridge_resp_t resp_cl;
  logic         resp_cl_valid;
  logic         resp_cl_ready;

  axi_lite_req_slave i_slave (
    .clk_i        (clk_i),
    .reset_i      (reset_i),
    .awaddr_i     (awaddr_i),
    .awvalid_i    (awvalid_i),
    .awready_o    (awready_o),
    .wdata_i      (wdata_i),
    .wstrb_i      (wstrb_i),
    .wvalid_i     (wvalid_i),
    .wready_o     (wready_o),
    .bresp_o      (bresp_o),
    .bvalid_o     (bvalid_o),
    .bready_i     (bready_i),
    .araddr_i     (araddr_i),
    .arvalid_i    (arvalid_i),
    .arready_o    (arready_o),
    .rdata_o      (rdata_o),
    .rresp_o      (rresp_o),
    .rvalid_o     (rvalid_o),
    .rready_i     (rready_i),
    .req_o        (req_cl),
    .req_valid_o  (req_cl_valid),
    .req_ready_i  (req_cl_ready),
    .resp_i       (resp_cl),
    .resp_valid_i (resp_cl_valid),
    .resp_ready_o (resp_cl_ready)
  );

  async_token_fifo #(
    .DATA_WIDTH (REQ_WIDTH)
  ) i_req_fifo (
    .wr_clk_i   (clk_i),
    .rd_clk_i   (soc_clk_i),
    .reset_i    (reset_i),
    .wr_data_i  (req_cl),
    .wr_valid_i (req_cl_valid),
    .wr_ready_o (req_cl_ready),
    .rd_data_o  (req_soc),
    .rd_valid_o (req_soc_valid),
    .rd_ready_i (req_soc_ready)
  );

  reg_bank_target i_target (
    .soc_clk_i    (soc_clk_i),
    .reset_i      (reset_i),
    .req_i        (req_soc),
    .req_valid_i  (req_soc_valid),
    .req_ready_o  (req_soc_ready),
    .resp_o       (resp_soc),
    .resp_valid_o (resp_soc_valid),
    .resp_ready_i (resp_soc_ready)
  );

  async_token_fifo #(
    .DATA_WIDTH (RESP_WIDTH)
  ) i_resp_fifo (
    .wr_clk_i   (soc_clk_i),
    .rd_clk_i   (clk_i),
    .reset_i    (reset_i),
    .wr_data_i  (resp_soc),
    .wr_valid_i (resp_soc_valid),
    .wr_ready_o (resp_soc_ready),
    .rd_data_o  (resp_cl),
    .rd_valid_o (resp_cl_valid),
    .rd_ready_i (resp_cl_ready)
  );

endmodule

/* testbench/tb_axi_lite_async_bridge.sv */
`timescale 1ns/1ps

module tb_axi_lite_async_bridge import axi_lite_async_pkg::*;
();

  logic                  clk_i;
  logic                  soc_clk_i;
  logic                  reset_i;
  logic [ADDR_WIDTH-1:0] awaddr_i;
  logic                  awvalid_i;
  logic                  awready_o;
  logic [DATA_WIDTH-1:0] wdata_i;
  logic [STRB_WIDTH-1:0] wstrb_i;
  logic                  wvalid_i;
  logic                  wready_o;
  logic [1:0]            bresp_o;
  logic                  bvalid_o;
  logic                  bready_i = 1'b0;
  logic [ADDR_WIDTH-1:0] araddr_i;
  logic                  arvalid_i;
  logic                  arready_o;
  logic [DATA_WIDTH-1:0] rdata_o;
  logic [1:0]            rresp_o;
  logic                  rvalid_o;
  logic                  rready_i = 1'b0;

  int error_count   = 0;
  int timeout_count = 0;
  int writes_sent   = 0;
  int reads_sent    = 0;
  int b_seen        = 0;
  int r_seen        = 0;
  int max_wait      = 200;
  int b_stretch     = 0;
  int r_stretch     = 0;
  bit aborted       = 1'b0;

  axi_lite_async_bridge_top DUT (.*);

  initial
  begin
    clk_i = 1'b0;
    forever #5 clk_i = ~clk_i;
  end

  initial
  begin
    soc_clk_i = 1'b0;
    #3; // keeps the two domains out of phase.
    forever #5 soc_clk_i = ~soc_clk_i;
  end

  // back-pressure on B and R comes in random stretches of one to four cycles.
  always @(posedge clk_i)
  begin
    if (reset_i)
    begin
      bready_i <= 1'b0;
      rready_i <= 1'b0;
    end
    else
    begin
      if (b_stretch == 0)
      begin
        bready_i  <= ($urandom % 3) != 0;
        b_stretch <= $urandom % 4;
      end
      else
        b_stretch <= b_stretch - 1;
      if (r_stretch == 0)
      begin
        rready_i  <= ($urandom % 3) != 0;
        r_stretch <= $urandom % 4;
      end
      else
        r_stretch <= r_stretch - 1;
    end
  end

  // counts every response handshake, so a duplicate or a lost response shows at the end.
  always @(posedge clk_i)
  begin
    if (!reset_i)
    begin
      assert (!(bvalid_o && rvalid_o))
      else
      begin
        $display("bvalid_o and rvalid_o were high in the same cycle at %0t", $time);
        error_count++;
      end
      if (bvalid_o && bready_i)
        b_seen++;
      if (rvalid_o && rready_i)
        r_seen++;
    end
  end

  task automatic report_timeout(input string what);
    $display("timeout after %0d cycles, %s", max_wait, what);
    timeout_count++;
    aborted = 1'b1;
  endtask

  task automatic run_write(input logic [ADDR_WIDTH-1:0] addr, input logic [DATA_WIDTH-1:0] data,
                           input logic [STRB_WIDTH-1:0] strb, input logic [1:0] exp_resp);
    int cycles;
    bit done;
    cycles = 0;
    done   = 1'b0;
    awaddr_i  <= addr;
    awvalid_i <= 1'b1;
    wdata_i   <= data;
    wstrb_i   <= strb;
    wvalid_i  <= 1'b1;
    writes_sent++;
    while (!done && cycles < max_wait)
    begin
      @(posedge clk_i);
      cycles++;
      done = awready_o && wready_o;
    end
    awvalid_i <= 1'b0;
    wvalid_i  <= 1'b0;
    if (!done)
    begin
      report_timeout("the write address and data channels were never accepted");
      return;
    end
    cycles = 0;
    done   = 1'b0;
    while (!done && cycles < max_wait)
    begin
      @(posedge clk_i);
      cycles++;
      done = bvalid_o && bready_i;
    end
    if (!done)
    begin
      report_timeout("no write response arrived on the B channel");
      return;
    end
    assert (bresp_o == exp_resp)
    else
    begin
      $display("error bresp_o exp %h got %h at address %h", exp_resp, bresp_o, addr);
      error_count++;
    end
  endtask

  task automatic run_read(input logic [ADDR_WIDTH-1:0] addr, input logic [1:0] exp_resp,
                          input logic [DATA_WIDTH-1:0] exp_rdata);
    int cycles;
    bit done;
    cycles = 0;
    done   = 1'b0;
    araddr_i  <= addr;
    arvalid_i <= 1'b1;
    reads_sent++;
    while (!done && cycles < max_wait)
    begin
      @(posedge clk_i);
      cycles++;
      done = arready_o;
    end
    arvalid_i <= 1'b0;
    if (!done)
    begin
      report_timeout("the read address channel was never accepted");
      return;
    end
    cycles = 0;
    done   = 1'b0;
    while (!done && cycles < max_wait)
    begin
      @(posedge clk_i);
      cycles++;
      done = rvalid_o && rready_i;
    end
    if (!done)
    begin
      report_timeout("no read response arrived on the R channel");
      return;
    end
    assert (rresp_o == exp_resp)
    else
    begin
      $display("error rresp_o exp %h got %h at address %h", exp_resp, rresp_o, addr);
      error_count++;
    end
    assert (rdata_o == exp_rdata)
    else
    begin
      $display("error rdata_o exp %h got %h at address %h", exp_rdata, rdata_o, addr);
      error_count++;
    end
  endtask

  initial
  begin
    int                    fd;
    int                    seed;
    logic [8*200-1:0]      line_buf;
    logic                  op;
    logic [ADDR_WIDTH-1:0] addr;
    logic [DATA_WIDTH-1:0] data;
    logic [STRB_WIDTH-1:0] strb;
    logic [1:0]            exp_resp;
    logic [DATA_WIDTH-1:0] exp_rdata;

    seed = $urandom(98);
    reset_i   <= 1'b1;
    awaddr_i  <= '0;
    awvalid_i <= 1'b0;
    wdata_i   <= '0;
    wstrb_i   <= '0;
    wvalid_i  <= 1'b0;
    araddr_i  <= '0;
    arvalid_i <= 1'b0;
    repeat (10) @(posedge clk_i);
    reset_i <= 1'b0;

    fd = $fopen("testbench/bridge_golden.txt", "r");
    if (fd == 0)
    begin
      $display("could not open testbench/bridge_golden.txt");
      error_count++;
    end
    else
    begin
      while (!aborted && $fgets(line_buf, fd) != 0)
      begin
        // comment lines match no field and are skipped.
        if ($sscanf(line_buf, "%h %h %h %h %h %h", op, addr, data, strb, exp_resp,
                    exp_rdata) == 6)
        begin
          repeat ($urandom % 4) @(posedge clk_i);
          if (op)
            run_write(addr, data, strb, exp_resp);
          else
            run_read(addr, exp_resp, exp_rdata);
        end
      end
      $fclose(fd);
    end

    repeat (20) @(posedge clk_i); // lets any stray response show up in the counts.
    assert (b_seen == writes_sent)
    else
    begin
      $display("error b_seen exp %h got %h", writes_sent, b_seen);
      error_count++;
    end
    assert (r_seen == reads_sent)
    else
    begin
      $display("error r_seen exp %h got %h", reads_sent, r_seen);
      error_count++;
    end

    $display("%0d writes, %0d reads, %0d errors, %0d timeouts", writes_sent, reads_sent,
             error_count, timeout_count);
    if (error_count == 0 && timeout_count == 0)
      $display("ALL TESTS PASSED");
    else
      $display("SOME TESTS FAILED");
    $finish;
  end

endmodule

/* testbench/bridge_golden.txt */
# one transaction per line, all hex: op (1 write, 0 read) address wdata wstrb resp rdata
# resp 0 is OKAY and 2 is SLVERR, the rdata column is ignored for writes
0 00001000 00000000 0 0 00000000
0 00001004 00000000 0 0 00000000
0 00001008 00000000 0 0 00000000
0 0000100c 00000000 0 0 00000000
0 00001010 00000000 0 0 00000000
0 00001014 00000000 0 0 00000000
0 00001018 00000000 0 0 00000000
0 0000101c 00000000 0 0 00000000
0 00001020 00000000 0 0 00000000
0 00001024 00000000 0 0 00000000
0 00001028 00000000 0 0 00000000
0 0000102c 00000000 0 0 00000000
0 00001030 00000000 0 0 00000000
0 00001034 00000000 0 0 00000000
0 00001038 00000000 0 0 00000000
0 0000103c 00000000 0 0 00000000
1 00001000 deadbeef f 0 00000000
0 00001000 00000000 0 0 deadbeef
1 00001004 11223344 f 0 00000000
1 00001004 aabbccdd 5 0 00000000
0 00001004 00000000 0 0 11bb33dd
1 00001008 1234beef 3 0 00000000
0 00001008 00000000 0 0 0000beef
1 0000103c 5a5a5a5a 8 0 00000000
0 0000103c 00000000 0 0 5a000000
1 00001040 12345678 f 2 00000000
0 00001040 00000000 0 2 00000000
0 00001002 00000000 0 2 00000000
1 00001006 ffffffff 3 2 00000000
1 00000ffc 0badf00d f 2 00000000
0 00002000 00000000 0 2 00000000
0 00001000 00000000 0 0 deadbeef
0 00001004 00000000 0 0 11bb33dd

/* compile.f */
verilog/axi_lite_async_pkg.sv
verilog/level_shift_sync_wrap.sv
verilog/async_token_fifo.sv
verilog/axi_lite_req_slave.sv
verilog/reg_bank_target.sv
verilog/axi_lite_async_bridge_top.sv
testbench/tb_axi_lite_async_bridge.sv

/* Bender.yml */
package:
  name: axi_lite_async_bridge

sources:
  - files:
      - verilog/axi_lite_async_pkg.sv
      - verilog/level_shift_sync_wrap.sv
      - verilog/async_token_fifo.sv
      - verilog/axi_lite_req_slave.sv
      - verilog/reg_bank_target.sv
      - verilog/axi_lite_async_bridge_top.sv

  - target: test
    files:
      - testbench/tb_axi_lite_async_bridge.sv
